//--- hdl/nts_engine_pkg.sv
//------------------------------------------------
// Shared address map, constants and types for the
// NTS engine control block. Imported by every RTL file.
//------------------------------------------------

package nts_engine_pkg;

  //------------------------------------------------
  // Widths
  //------------------------------------------------

  localparam int API_DATA_W = 32;  // Register word
  localparam int API_ADDR_W = 12;  // External address
  localparam int API_WORD_W = 8;   // Block-local word address
  localparam int BLK_W      = API_ADDR_W - API_WORD_W;
  localparam int NUM_STATS  = 6;

  //------------------------------------------------
  // Engine register block
  //------------------------------------------------

  localparam logic [API_WORD_W-1:0] ADDR_NAME0   = 8'h00;
  localparam logic [API_WORD_W-1:0] ADDR_NAME1   = 8'h01;
  localparam logic [API_WORD_W-1:0] ADDR_VERSION = 8'h02;
  localparam logic [API_WORD_W-1:0] ADDR_CTRL    = 8'h08;
  localparam logic [API_WORD_W-1:0] ADDR_STATUS  = 8'h09;

  localparam logic [API_DATA_W-1:0] CORE_NAME0   = 32'h4e54_535f;  // "NTS_"
  localparam logic [API_DATA_W-1:0] CORE_NAME1   = 32'h454e_474e;  // "ENGN"
  localparam logic [API_DATA_W-1:0] CORE_VERSION = 32'h302e_3035;  // "0.05"

  //------------------------------------------------
  // Debug register block
  //------------------------------------------------

  // Counters take two words, high half first
  localparam logic [API_WORD_W-1:0] ADDR_DBG_PROCESSED  = 8'h00;
  localparam logic [API_WORD_W-1:0] ADDR_DBG_BAD_COOKIE = 8'h02;
  localparam logic [API_WORD_W-1:0] ADDR_DBG_BAD_AUTH   = 8'h04;
  localparam logic [API_WORD_W-1:0] ADDR_DBG_BAD_KEYID  = 8'h06;
  localparam logic [API_WORD_W-1:0] ADDR_DBG_NAME       = 8'h08;
  localparam logic [API_WORD_W-1:0] ADDR_DBG_SYSTICK    = 8'h09;
  localparam logic [API_WORD_W-1:0] ADDR_DBG_ERR_CRYPTO = 8'h20;
  localparam logic [API_WORD_W-1:0] ADDR_DBG_ERR_TXBUF  = 8'h22;

  localparam logic [API_DATA_W-1:0] DEBUG_NAME    = 32'h4442_5547;  // "DBUG"
  localparam logic [API_DATA_W-1:0] SYSTICK_RESET = 32'd1;

  //------------------------------------------------
  // Types
  //------------------------------------------------

  // Block select from address bits 11:8
  typedef enum logic [BLK_W-1:0] {
    BLK_ENGINE = 4'd0,
    BLK_CLOCK  = 4'd1,
    BLK_COOKIE = 4'd2,
    BLK_KEYMEM = 4'd3,
    BLK_DEBUG  = 4'd4,
    BLK_PARSER = 4'd5
  } api_block_e;

  typedef struct packed {
    logic                  cs;
    logic                  we;
    logic [API_WORD_W-1:0] addr;
    logic [API_DATA_W-1:0] wdata;
  } api_req_t;

  // First field lands in the MSB
  typedef struct packed {
    logic nts_processed;
    logic nts_bad_cookie;
    logic nts_bad_auth;
    logic nts_bad_keyid;
    logic error_crypto;
    logic error_txbuf;
  } stat_events_t;

  typedef enum logic [2:0] {
    STAT_NTS_PROCESSED  = 3'd0,
    STAT_NTS_BAD_COOKIE = 3'd1,
    STAT_NTS_BAD_AUTH   = 3'd2,
    STAT_NTS_BAD_KEYID  = 3'd3,
    STAT_ERROR_CRYPTO   = 3'd4,
    STAT_ERROR_TXBUF    = 3'd5
  } stat_id_e;

  typedef struct packed {
    logic nts_processed;
    logic nts_bad_cookie;
    logic nts_bad_auth;
    logic nts_bad_keyid;
    logic error_crypto;
    logic error_txbuf;
  } stat_snap_t;

endpackage

//--- hdl/nts_stat_counter.sv
//------------------------------------------------
// 64-bit statistics counter. The low half is copied
// to a snapshot register when the high half is read.
//------------------------------------------------

module nts_stat_counter (
  input  logic                                  i_clk,
  input  logic                                  i_areset,
  input  logic                                  i_inc,       // One event
  input  logic                                  i_snapshot,  // High half being read
  output logic [nts_engine_pkg::API_DATA_W-1:0] o_msb,
  output logic [nts_engine_pkg::API_DATA_W-1:0] o_lsb_snap
);
  import nts_engine_pkg::*;

  logic [2*API_DATA_W-1:0] cnt_reg;
  logic [API_DATA_W-1:0]   lsb_snap_reg;

  //------------------------------------------------
  // Event count
  //------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      cnt_reg <= '0;
    end
    else if (i_inc)
    begin
      cnt_reg <= cnt_reg + 1'b1;
    end
  end

  //------------------------------------------------
  // Low half snapshot
  //------------------------------------------------

  // Sampled before this edge's increment, so it pairs with o_msb
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      lsb_snap_reg <= '0;
    end
    else if (i_snapshot)
    begin
      lsb_snap_reg <= cnt_reg[API_DATA_W-1:0];
    end
  end

  assign o_msb      = cnt_reg[2*API_DATA_W-1:API_DATA_W];  // Live value
  assign o_lsb_snap = lsb_snap_reg;

endmodule

//--- hdl/nts_engine_regs.sv
//------------------------------------------------
// Engine register block. Identification words, the
// control enable and status, and the o_busy output.
//------------------------------------------------

module nts_engine_regs (
  input  logic                                  i_clk,
  input  logic                                  i_areset,
  input  nts_engine_pkg::api_req_t              i_req,
  input  logic                                  i_sel,
  input  logic                                  i_parser_busy,
  output logic [nts_engine_pkg::API_DATA_W-1:0] o_rdata,
  output logic                                  o_busy
);
  import nts_engine_pkg::*;

  logic access;
  logic ctrl_we;
  logic ctrl_reg;  // Engine enable

  assign access  = i_sel && i_req.cs;
  assign ctrl_we = access && i_req.we && (i_req.addr == ADDR_CTRL);

  //------------------------------------------------
  // Control register
  //------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      ctrl_reg <= 1'b0;  // Engine starts disabled
    end
    else if (ctrl_we)
    begin
      ctrl_reg <= i_req.wdata[0];
    end
  end

  // Busy while disabled or while the parser works
  assign o_busy = !ctrl_reg || i_parser_busy;

  //------------------------------------------------
  // Read data
  //------------------------------------------------

  always_comb
  begin
    o_rdata = '0;
    if (access && !i_req.we)
    begin
      case (i_req.addr)
        ADDR_NAME0:   o_rdata = CORE_NAME0;
        ADDR_NAME1:   o_rdata = CORE_NAME1;
        ADDR_VERSION: o_rdata = CORE_VERSION;
        ADDR_CTRL:
        begin
          o_rdata = {{(API_DATA_W-1){1'b0}}, ctrl_reg};
        end
        ADDR_STATUS:
        begin
          // Bit 0 is the ready flag
          o_rdata = {{(API_DATA_W-1){1'b0}}, !i_parser_busy};
        end
        default: o_rdata = '0;
      endcase
    end
  end

  //------------------------------------------------
  // Checks
  //------------------------------------------------

  a_ctrl_write: assert property (
    @(posedge i_clk) disable iff (i_areset)
    ctrl_we |=> (ctrl_reg == $past(i_req.wdata[0]))
  );

endmodule

//--- hdl/nts_debug_regs.sv
//------------------------------------------------
// Debug register block. Six statistics counters,
// a free-running tick counter and the name word. Read only.
//------------------------------------------------

module nts_debug_regs (
  input  logic                                  i_clk,
  input  logic                                  i_areset,
  input  nts_engine_pkg::api_req_t              i_req,
  input  logic                                  i_sel,
  input  nts_engine_pkg::stat_events_t          i_events,
  output logic [nts_engine_pkg::API_DATA_W-1:0] o_rdata
);
  import nts_engine_pkg::*;

  logic [API_DATA_W-1:0] cnt_msb [NUM_STATS];
  logic [API_DATA_W-1:0] cnt_lsb [NUM_STATS];
  stat_snap_t            snap;
  logic                  rd_en;
  logic [API_DATA_W-1:0] systick_reg;

  assign rd_en = i_sel && i_req.cs && !i_req.we;  // Writes ignored

  //------------------------------------------------
  // Statistics counters
  //------------------------------------------------

  // Counter g sits at struct bit NUM_STATS-1-g
  for (genvar g = 0; g < NUM_STATS; g++)
  begin : g_stat
    nts_stat_counter counter_i (
      .i_clk      ( i_clk                   ),
      .i_areset   ( i_areset                ),
      .i_inc      ( i_events[NUM_STATS-1-g] ),
      .i_snapshot ( snap[NUM_STATS-1-g]     ),
      .o_msb      ( cnt_msb[g]              ),
      .o_lsb_snap ( cnt_lsb[g]              )
    );
  end

  //------------------------------------------------
  // Tick counter
  //------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      systick_reg <= SYSTICK_RESET;
    end
    else
    begin
      systick_reg <= systick_reg + 1'b1;  // Wraps freely
    end
  end

  //------------------------------------------------
  // Read decode
  //------------------------------------------------

  always_comb
  begin
    o_rdata = '0;
    snap    = '0;
    if (rd_en)
    begin
      case (i_req.addr)
        ADDR_DBG_PROCESSED:
        begin
          o_rdata            = cnt_msb[STAT_NTS_PROCESSED];
          snap.nts_processed = 1'b1;
        end
        ADDR_DBG_PROCESSED + 8'd1:  o_rdata = cnt_lsb[STAT_NTS_PROCESSED];
        ADDR_DBG_BAD_COOKIE:
        begin
          o_rdata             = cnt_msb[STAT_NTS_BAD_COOKIE];
          snap.nts_bad_cookie = 1'b1;
        end
        ADDR_DBG_BAD_COOKIE + 8'd1: o_rdata = cnt_lsb[STAT_NTS_BAD_COOKIE];
        ADDR_DBG_BAD_AUTH:
        begin
          o_rdata           = cnt_msb[STAT_NTS_BAD_AUTH];
          snap.nts_bad_auth = 1'b1;
        end
        ADDR_DBG_BAD_AUTH + 8'd1:   o_rdata = cnt_lsb[STAT_NTS_BAD_AUTH];
        ADDR_DBG_BAD_KEYID:
        begin
          o_rdata            = cnt_msb[STAT_NTS_BAD_KEYID];
          snap.nts_bad_keyid = 1'b1;
        end
        ADDR_DBG_BAD_KEYID + 8'd1:  o_rdata = cnt_lsb[STAT_NTS_BAD_KEYID];
        ADDR_DBG_NAME:              o_rdata = DEBUG_NAME;
        ADDR_DBG_SYSTICK:           o_rdata = systick_reg;
        ADDR_DBG_ERR_CRYPTO:
        begin
          o_rdata           = cnt_msb[STAT_ERROR_CRYPTO];
          snap.error_crypto = 1'b1;
        end
        ADDR_DBG_ERR_CRYPTO + 8'd1: o_rdata = cnt_lsb[STAT_ERROR_CRYPTO];
        ADDR_DBG_ERR_TXBUF:
        begin
          o_rdata          = cnt_msb[STAT_ERROR_TXBUF];
          snap.error_txbuf = 1'b1;
        end
        ADDR_DBG_ERR_TXBUF + 8'd1:  o_rdata = cnt_lsb[STAT_ERROR_TXBUF];
        default:                    o_rdata = '0;  // Unmapped word
      endcase
    end
  end

  //------------------------------------------------
  // Checks
  //------------------------------------------------

  // One read per cycle, so only one counter may freeze its low half
  a_snap_onehot: assert property (
    @(posedge i_clk) disable iff (i_areset)
    $onehot0(snap)
  );

endmodule

//--- hdl/nts_api_decode.sv
//------------------------------------------------
// API decoder. Splits external accesses into block
// selects and returns read data one cycle later.
//------------------------------------------------

module nts_api_decode (
  input  logic                                  i_clk,
  input  logic                                  i_areset,
  input  logic                                  i_api_cs,
  input  logic                                  i_api_we,
  input  logic [nts_engine_pkg::API_ADDR_W-1:0] i_api_address,
  input  logic [nts_engine_pkg::API_DATA_W-1:0] i_api_write_data,
  output nts_engine_pkg::api_req_t              o_req,
  output logic                                  o_sel_engine,
  output logic                                  o_sel_debug,
  input  logic [nts_engine_pkg::API_DATA_W-1:0] i_rdata_engine,
  input  logic [nts_engine_pkg::API_DATA_W-1:0] i_rdata_debug,
  output logic [nts_engine_pkg::API_DATA_W-1:0] o_api_read_data,
  output logic                                  o_api_read_data_valid
);
  import nts_engine_pkg::*;

  api_block_e            block;
  logic                  rd_strobe;
  logic [API_DATA_W-1:0] rdata_mux;
  logic [API_DATA_W-1:0] rdata_reg;
  logic                  valid_reg;

  //------------------------------------------------
  // Request and selects
  //------------------------------------------------

  assign block     = api_block_e'(i_api_address[API_ADDR_W-1:API_WORD_W]);
  assign rd_strobe = i_api_cs && !i_api_we;

  assign o_req.cs    = i_api_cs;
  assign o_req.we    = i_api_we;
  assign o_req.addr  = i_api_address[API_WORD_W-1:0];
  assign o_req.wdata = i_api_write_data;

  assign o_sel_engine = i_api_cs && (block == BLK_ENGINE);
  assign o_sel_debug  = i_api_cs && (block == BLK_DEBUG);

  // Clock, cookie, keymem and parser have no registers here
  always_comb
  begin
    case (block)
      BLK_ENGINE: rdata_mux = i_rdata_engine;
      BLK_DEBUG:  rdata_mux = i_rdata_debug;
      default:    rdata_mux = '0;
    endcase
  end

  //------------------------------------------------
  // Read response
  //------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      valid_reg <= 1'b0;
    end
    else
    begin
      valid_reg <= rd_strobe;  // One pulse per read
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (rd_strobe)
    begin
      rdata_reg <= rdata_mux;
    end
  end

  assign o_api_read_data       = rdata_reg;
  assign o_api_read_data_valid = valid_reg;

  a_valid_after_read: assert property (
    @(posedge i_clk) disable iff (i_areset)
    o_api_read_data_valid |-> $past(i_api_cs && !i_api_we)
  );

endmodule

//--- hdl/nts_engine_ctrl.sv
//------------------------------------------------
// NTS engine control top. Register API decoder with
// the engine and debug register blocks behind it.
//------------------------------------------------

module nts_engine_ctrl (
  input  logic                                  i_clk,
  input  logic                                  i_areset,

  // External register API
  input  logic                                  i_api_cs,
  input  logic                                  i_api_we,
  input  logic [nts_engine_pkg::API_ADDR_W-1:0] i_api_address,
  input  logic [nts_engine_pkg::API_DATA_W-1:0] i_api_write_data,
  output logic [nts_engine_pkg::API_DATA_W-1:0] o_api_read_data,
  output logic                                  o_api_read_data_valid,

  // Statistics and status
  input  nts_engine_pkg::stat_events_t          i_events,
  input  logic                                  i_parser_busy,
  output logic                                  o_busy
);
  import nts_engine_pkg::*;

  api_req_t              req;
  logic                  sel_engine;
  logic                  sel_debug;
  logic [API_DATA_W-1:0] rdata_engine;
  logic [API_DATA_W-1:0] rdata_debug;

  //------------------------------------------------
  // API decoder
  //------------------------------------------------

  nts_api_decode api_decode_i (
    .i_clk                 ( i_clk                 ),
    .i_areset              ( i_areset              ),
    .i_api_cs              ( i_api_cs              ),
    .i_api_we              ( i_api_we              ),
    .i_api_address         ( i_api_address         ),
    .i_api_write_data      ( i_api_write_data      ),
    .o_req                 ( req                   ),
    .o_sel_engine          ( sel_engine            ),
    .o_sel_debug           ( sel_debug             ),
    .i_rdata_engine        ( rdata_engine          ),
    .i_rdata_debug         ( rdata_debug           ),
    .o_api_read_data       ( o_api_read_data       ),
    .o_api_read_data_valid ( o_api_read_data_valid )
  );

  //------------------------------------------------
  // Register blocks
  //------------------------------------------------

  nts_engine_regs engine_regs_i (
    .i_clk         ( i_clk         ),
    .i_areset      ( i_areset      ),
    .i_req         ( req           ),
    .i_sel         ( sel_engine    ),
    .i_parser_busy ( i_parser_busy ),
    .o_rdata       ( rdata_engine  ),
    .o_busy        ( o_busy        )
  );

  nts_debug_regs debug_regs_i (
    .i_clk    ( i_clk       ),
    .i_areset ( i_areset    ),
    .i_req    ( req         ),
    .i_sel    ( sel_debug   ),
    .i_events ( i_events    ),
    .o_rdata  ( rdata_debug )
  );

endmodule

//--- verif/tb_clock_gen.sv
//------------------------------------------------
// Testbench clock and reset. Reset is released one
// time unit after the last reset clock edge.
//------------------------------------------------

module tb_clock_gen #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 5
) (
  output logic o_clk,
  output logic o_areset
);

  initial
  begin
    o_clk    = 1'b0;
    o_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_areset = 1'b0;  // Clear of the edge
  end

  always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

//--- verif/tb_nts_engine_ctrl.sv
//------------------------------------------------
// Testbench for the NTS engine control top. Drives API
// accesses and events, checks reads against a model.
//------------------------------------------------

module tb_nts_engine_ctrl;
  import nts_engine_pkg::*;

  localparam logic [31:0] SEED = 32'h1d1b_d83c;
  localparam int N_RANDOM    = 200;  // Random event cycles
  localparam int N_TICK      = 17;   // Spacing of the two tick reads
  localparam int N_FIXED     = 110;  // Directed sections and drains
  localparam int STIM_CYCLES = N_RANDOM + N_TICK + N_FIXED;
  localparam int TIMEOUT     = 2 * STIM_CYCLES + 100;

  // Debug words 0a, 10, 24, ff, then clock, cookie, keymem and parser blocks
  localparam logic [API_ADDR_W-1:0] UNMAPPED [8] = '{
    12'h40a, 12'h410, 12'h424, 12'h4ff, 12'h100, 12'h202, 12'h308, 12'h509
  };

  logic                  clk;
  logic                  areset;
  logic                  api_cs;
  logic                  api_we;
  logic [API_ADDR_W-1:0] api_address;
  logic [API_DATA_W-1:0] api_write_data;
  logic [API_DATA_W-1:0] api_read_data;
  logic                  api_read_data_valid;
  stat_events_t          events;
  logic                  parser_busy;
  logic                  busy;

  // Reference model state
  logic [2*API_DATA_W-1:0] model_cnt [NUM_STATS];
  logic [API_DATA_W-1:0]   model_snap [NUM_STATS];
  logic                    model_ctrl;
  logic                    model_busy;
  logic [API_DATA_W-1:0]   tick_cnt;

  logic [API_DATA_W-1:0] exp_q [$];  // Expected read data in issue order
  logic [API_DATA_W-1:0] last_rdata;
  logic [API_DATA_W-1:0] prev_rdata;
  logic                  rd_pending;
  int                    errors    = 0;
  int                    checks    = 0;
  int                    cycle_cnt = 0;

  tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(5)) clock_gen_i (
    .o_clk    ( clk    ),
    .o_areset ( areset )
  );

  nts_engine_ctrl dut_i (
    .i_clk                 ( clk                 ),
    .i_areset              ( areset              ),
    .i_api_cs              ( api_cs              ),
    .i_api_we              ( api_we              ),
    .i_api_address         ( api_address         ),
    .i_api_write_data      ( api_write_data      ),
    .o_api_read_data       ( api_read_data       ),
    .o_api_read_data_valid ( api_read_data_valid ),
    .i_events              ( events              ),
    .i_parser_busy         ( parser_busy         ),
    .o_busy                ( busy                )
  );

  //------------------------------------------------
  // Helpers and reference model
  //------------------------------------------------

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic logic [API_ADDR_W-1:0] engine_addr(input logic [API_WORD_W-1:0] w);
    return {BLK_ENGINE, w};
  endfunction

  function automatic logic [API_ADDR_W-1:0] debug_addr(input logic [API_WORD_W-1:0] w);
    return {BLK_DEBUG, w};
  endfunction

  // High half address of each counter
  function automatic logic [API_WORD_W-1:0] counter_word(input int id);
    case (id)
      STAT_NTS_PROCESSED:  return ADDR_DBG_PROCESSED;
      STAT_NTS_BAD_COOKIE: return ADDR_DBG_BAD_COOKIE;
      STAT_NTS_BAD_AUTH:   return ADDR_DBG_BAD_AUTH;
      STAT_NTS_BAD_KEYID:  return ADDR_DBG_BAD_KEYID;
      STAT_ERROR_CRYPTO:   return ADDR_DBG_ERR_CRYPTO;
      default:             return ADDR_DBG_ERR_TXBUF;
    endcase
  endfunction

  function automatic logic [API_DATA_W-1:0] expected_read(input logic [API_ADDR_W-1:0] addr);
    logic [API_WORD_W-1:0] word;
    logic [API_DATA_W-1:0] value;
    word  = addr[API_WORD_W-1:0];
    value = '0;
    if (addr[API_ADDR_W-1:API_WORD_W] == BLK_ENGINE)
    begin
      case (word)
        ADDR_NAME0:   value = CORE_NAME0;
        ADDR_NAME1:   value = CORE_NAME1;
        ADDR_VERSION: value = CORE_VERSION;
        ADDR_CTRL:    value = {31'b0, model_ctrl};
        ADDR_STATUS:  value = {31'b0, !model_busy};  // Ready flag
        default:      value = '0;
      endcase
    end
    else if (addr[API_ADDR_W-1:API_WORD_W] == BLK_DEBUG)
    begin
      if (word == ADDR_DBG_NAME)
        value = DEBUG_NAME;
      if (word == ADDR_DBG_SYSTICK)
        value = SYSTICK_RESET + tick_cnt;
      for (int i = 0; i < NUM_STATS; i++)
      begin
        if (word == counter_word(i))
          value = model_cnt[i][2*API_DATA_W-1:API_DATA_W];
        if (word == counter_word(i) + 8'd1)
          value = model_snap[i];  // Frozen low half
      end
    end
    return value;
  endfunction

  function automatic logic [NUM_STATS-1:0] random_events();
    logic [31:0] r;
    r = $urandom;
    return r[NUM_STATS-1:0];
  endfunction

  // One bus cycle, driven just after the rising edge
  task automatic access(input logic cs, input logic we, input logic [API_ADDR_W-1:0] addr,
                        input logic [API_DATA_W-1:0] wdata, input logic [NUM_STATS-1:0] ev);
    @(posedge clk);
    #1;
    api_cs         = cs;
    api_we         = we;
    api_address    = addr;
    api_write_data = wdata;
    events         = ev;
    parser_busy    = model_busy;
    if (cs && !we)
    begin
      exp_q.push_back(expected_read(addr));  // Count before this cycle's events
      for (int i = 0; i < NUM_STATS; i++)
      begin
        if (addr == debug_addr(counter_word(i)))
          model_snap[i] = model_cnt[i][API_DATA_W-1:0];
      end
    end
    if (cs && we && addr == engine_addr(ADDR_CTRL))
      model_ctrl = wdata[0];
    for (int i = 0; i < NUM_STATS; i++)
    begin
      if (ev[NUM_STATS-1-i])  // First struct field is the MSB
        model_cnt[i] = model_cnt[i] + 1'b1;
    end
  endtask

  task automatic read_word(input logic [API_ADDR_W-1:0] addr, input logic [NUM_STATS-1:0] ev);
    access(1'b1, 1'b0, addr, '0, ev);
  endtask

  task automatic write_word(input logic [API_ADDR_W-1:0] addr, input logic [API_DATA_W-1:0] d);
    access(1'b1, 1'b1, addr, d, '0);
  endtask

  task automatic idle(input int n);
    repeat (n) access(1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic event_stream(input int n);
    repeat (n) access(1'b0, 1'b0, '0, '0, random_events());
  endtask

  // Bus goes idle, then every outstanding read must come back
  task automatic drain();
    idle(1);
    wait (exp_q.size() == 0);
    @(negedge clk);
  endtask

  task automatic check_busy();
    @(negedge clk);
    check("o_busy", busy, !model_ctrl || model_busy);
  endtask

  //------------------------------------------------
  // Model tick count and response compare
  //------------------------------------------------

  always @(posedge clk or posedge areset)
  begin
    if (areset)
      tick_cnt <= '0;
    else
      tick_cnt <= tick_cnt + 1'b1;
  end

  always @(negedge clk)
  begin
    if (!areset)
    begin
      check("o_api_read_data_valid", api_read_data_valid, rd_pending);
      if (api_read_data_valid && exp_q.size() == 0)
      begin
        errors++;
        $display("Read data valid pulsed with no read outstanding at %0t", $time);
      end
      else if (api_read_data_valid)
      begin
        prev_rdata = last_rdata;
        last_rdata = api_read_data;
        check("o_api_read_data", api_read_data, exp_q.pop_front());
      end
      else if (rd_pending)
        void'(exp_q.pop_front());  // Lost response, keep queue aligned
    end
    rd_pending = api_cs && !api_we;  // Sampled at the next rising edge
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT)
    begin
      $display("Run did not finish within %0d cycles, %0d reads outstanding",
               TIMEOUT, exp_q.size());
      $display("Test failures found");
      $finish;
    end
  end

  //------------------------------------------------
  // Stimulus
  //------------------------------------------------

  initial
  begin
    api_cs         = 1'b0;
    api_we         = 1'b0;
    api_address    = '0;
    api_write_data = '0;
    events         = '0;
    parser_busy    = 1'b0;
    model_ctrl     = 1'b0;
    model_busy     = 1'b0;
    rd_pending     = 1'b0;
    last_rdata     = '0;
    prev_rdata     = '0;
    for (int i = 0; i < NUM_STATS; i++)
    begin
      model_cnt[i]  = '0;
      model_snap[i] = '0;
    end
    void'($urandom(SEED));

    @(negedge areset);
    idle(4);  // No reads, so no valid pulse
    check_busy();
    read_word(engine_addr(ADDR_NAME0), '0);
    read_word(engine_addr(ADDR_NAME1), '0);
    read_word(engine_addr(ADDR_VERSION), '0);
    read_word(debug_addr(ADDR_DBG_NAME), '0);
    read_word(engine_addr(ADDR_CTRL), '0);
    drain();

    // Control enable and busy
    write_word(engine_addr(ADDR_CTRL), 32'h1);
    read_word(engine_addr(ADDR_CTRL), '0);
    check_busy();
    model_busy = 1'b1;
    read_word(engine_addr(ADDR_STATUS), '0);
    check_busy();
    model_busy = 1'b0;
    read_word(engine_addr(ADDR_STATUS), '0);
    check_busy();
    write_word(engine_addr(ADDR_CTRL), 32'h0);
    read_word(engine_addr(ADDR_CTRL), '0);
    check_busy();
    drain();

    // Counters, quiet pairs then pairs with events in between
    event_stream(N_RANDOM);
    for (int i = 0; i < NUM_STATS; i++)
    begin
      read_word(debug_addr(counter_word(i)), '0);
      read_word(debug_addr(counter_word(i) + 8'd1), '0);
    end
    drain();
    for (int i = 0; i < NUM_STATS; i++)
    begin
      read_word(debug_addr(counter_word(i)), random_events());
      event_stream(3);
      read_word(debug_addr(counter_word(i) + 8'd1), random_events());
    end
    drain();

    // Tick counter, two reads N_TICK cycles apart
    read_word(debug_addr(ADDR_DBG_SYSTICK), '0);
    idle(N_TICK - 1);
    read_word(debug_addr(ADDR_DBG_SYSTICK), '0);
    drain();
    check("o_api_read_data (systick delta)", last_rdata - prev_rdata, N_TICK);

    // Unmapped words, unimplemented blocks and ignored debug writes
    foreach (UNMAPPED[i])
      read_word(UNMAPPED[i], '0);
    write_word(debug_addr(ADDR_DBG_NAME), 32'hffff_ffff);
    write_word(debug_addr(ADDR_DBG_PROCESSED), 32'hdead_beef);
    read_word(debug_addr(ADDR_DBG_NAME), '0);
    read_word(debug_addr(ADDR_DBG_PROCESSED), '0);
    read_word(debug_addr(ADDR_DBG_PROCESSED + 8'd1), '0);
    drain();

    // Back-to-back reads
    read_word(engine_addr(ADDR_NAME0), '0);
    read_word(engine_addr(ADDR_NAME1), '0);
    read_word(engine_addr(ADDR_VERSION), '0);
    read_word(debug_addr(ADDR_DBG_NAME), '0);
    read_word(debug_addr(ADDR_DBG_SYSTICK), '0);
    read_word(engine_addr(ADDR_CTRL), '0);
    read_word(engine_addr(ADDR_STATUS), '0);
    drain();
    idle(2);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- filelist.f
hdl/nts_engine_pkg.sv
hdl/nts_stat_counter.sv
hdl/nts_engine_regs.sv
hdl/nts_debug_regs.sv
hdl/nts_api_decode.sv
hdl/nts_engine_ctrl.sv
verif/tb_clock_gen.sv
verif/tb_nts_engine_ctrl.sv
